//--- source/well_pkg.sv
package well_pkg;

    // Cell coordinates, out of bounds at or above the well size
    typedef logic [3:0] col_t;
    typedef logic [4:0] row_t;

    typedef struct packed {
        col_t col;
        row_t row;
    } cell_pos_t;

    // Centre cell first, then the three outer cells
    typedef struct packed {
        cell_pos_t center;
        cell_pos_t b1;
        cell_pos_t b2;
        cell_pos_t b3;
    } piece_cells_t;

    // 0 is empty, otherwise shape + 1
    typedef logic [2:0] color_code_t;
    typedef logic [2:0] shape_t;
    typedef logic [1:0] rot_t;
    typedef logic [7:0] key_t;

    localparam key_t KEY_UP    = 8'h75;
    localparam key_t KEY_DOWN  = 8'h72;
    localparam key_t KEY_RIGHT = 8'h74;
    localparam key_t KEY_LEFT  = 8'h6B;

    localparam int SHAPE_COUNT = 7;

endpackage

//--- source/video_pkg.sv
package video_pkg;

    typedef logic [9:0] pixel_t;

    typedef struct packed {
        pixel_t x;
        pixel_t y;
    } pixel_pos_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Top-left corner of the well and cell pitch
    localparam pixel_t FIELD_X0 = 10'd220;
    localparam pixel_t FIELD_Y0 = 10'd40;
    localparam pixel_t CELL_PX  = 10'd20;

    localparam rgb_t RGB_BACKGROUND = '{r: 8'd20, g: 8'd20, b: 8'd20};
    localparam rgb_t RGB_GRID       = '{r: 8'd255, g: 8'd255, b: 8'd255};

    // Indexed by color code
    localparam rgb_t PALETTE [8] = '{
        RGB_BACKGROUND,
        '{r: 8'd255, g: 8'd20,  b: 8'd20},
        '{r: 8'd20,  g: 8'd255, b: 8'd20},
        '{r: 8'd20,  g: 8'd20,  b: 8'd255},
        '{r: 8'd20,  g: 8'd255, b: 8'd255},
        '{r: 8'd255, g: 8'd20,  b: 8'd255},
        '{r: 8'd255, g: 8'd255, b: 8'd20},
        '{r: 8'd255, g: 8'd100, b: 8'd0}
    };

endpackage

//--- source/piece_shape.sv
`timescale 1ns/1ps

module piece_shape (
    input  well_pkg::cell_pos_t    i_center,
    input  well_pkg::shape_t       i_shape,
    input  well_pkg::rot_t         i_rot,
    output well_pkg::piece_cells_t o_cells
);

    // Signed 3-bit offsets x1,y1,x2,y2,x3,y3 of the outer cells
    logic [17:0] offs;

    function automatic logic [17:0] offset_set(int x1, int y1, int x2, int y2,
                                               int x3, int y3);
        return {3'(x1), 3'(y1), 3'(x2), 3'(y2), 3'(x3), 3'(y3)};
    endfunction

    function automatic well_pkg::cell_pos_t add_offset(well_pkg::cell_pos_t c,
                                                       logic [5:0] d);
        well_pkg::cell_pos_t s;
        s.col = c.col + {d[5], d[5:3]};
        s.row = c.row + {{2{d[2]}}, d[2:0]};
        return s;
    endfunction

    always_comb begin
        case (i_shape)
            3'd0: offs = i_rot[0] ? offset_set(0, -1, -1, 0, -1, 1)
                                  : offset_set(-1, 0, 0, 1, 1, 1);
            3'd1: offs = i_rot[0] ? offset_set(-1, -1, -1, 0, 0, 1)
                                  : offset_set(-1, 1, 0, 1, 1, 0);
            3'd2: begin
                case (i_rot)
                    2'd0: offs = offset_set(-1, 0, 0, 1, 1, 0);
                    2'd1: offs = offset_set(-1, 0, 0, -1, 0, 1);
                    2'd2: offs = offset_set(-1, 0, 0, -1, 1, 0);
                    default: offs = offset_set(0, -1, 1, 0, 0, 1);
                endcase
            end
            3'd3: offs = i_rot[0] ? offset_set(0, -1, 0, 1, 0, 2)
                                  : offset_set(-1, 0, 1, 0, 2, 0);
            3'd4: begin
                case (i_rot)
                    2'd0: offs = offset_set(-1, 0, 1, 0, 1, 1);
                    2'd1: offs = offset_set(-1, 1, 0, -1, 0, 1);
                    2'd2: offs = offset_set(-1, -1, -1, 0, 1, 0);
                    default: offs = offset_set(0, -1, 0, 1, 1, -1);
                endcase
            end
            3'd5: begin
                case (i_rot)
                    2'd0: offs = offset_set(-1, 0, -1, 1, 1, 0);
                    2'd1: offs = offset_set(-1, -1, 0, -1, 0, 1);
                    2'd2: offs = offset_set(-1, 0, 1, 0, 1, -1);
                    default: offs = offset_set(0, -1, 0, 1, 1, 1);
                endcase
            end
            // Square, same in every rotation
            3'd6: offs = offset_set(0, 1, 1, 0, 1, 1);
            default: offs = offset_set(-1, 0, 0, 1, 1, 1);
        endcase
    end

    assign o_cells = '{i_center,
                       add_offset(i_center, offs[17:12]),
                       add_offset(i_center, offs[11:6]),
                       add_offset(i_center, offs[5:0])};

endmodule

//--- source/well_board.sv
`timescale 1ns/1ps

module well_board #(
    parameter int WELL_COLS = 10,
    parameter int WELL_ROWS = 20
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_clear_all,
    input  logic                   i_lock,
    input  well_pkg::piece_cells_t i_lock_cells,
    input  well_pkg::color_code_t  i_lock_color,
    input  well_pkg::piece_cells_t i_probe_now,
    input  well_pkg::piece_cells_t i_probe_below,
    output logic                   o_now_blocked,
    output logic                   o_below_blocked,
    input  well_pkg::cell_pos_t    i_cell_query,
    output well_pkg::color_code_t  o_cell_color,
    output logic                   o_clear_done,
    output logic [2:0]             o_rows_cleared
);

    localparam int CW = $clog2(WELL_COLS);
    localparam int RW = $clog2(WELL_ROWS);
    localparam well_pkg::col_t LAST_COL = well_pkg::col_t'(WELL_COLS - 1);
    localparam well_pkg::row_t LAST_ROW = well_pkg::row_t'(WELL_ROWS - 1);

    well_pkg::color_code_t cells_q [WELL_COLS][WELL_ROWS];
    well_pkg::cell_pos_t   lock_c [4];
    logic                  scan_q;
    well_pkg::row_t        scan_row_q;
    logic [2:0]            found_q;
    logic                  row_full;

    function automatic logic on_board(well_pkg::cell_pos_t p);
        return (p.col <= LAST_COL) && (p.row <= LAST_ROW);
    endfunction

    function automatic well_pkg::color_code_t color_at(well_pkg::cell_pos_t p);
        if (!on_board(p)) begin
            return '0;
        end
        return cells_q[p.col[CW-1:0]][p.row[RW-1:0]];
    endfunction

    function automatic logic blocked(well_pkg::piece_cells_t p);
        well_pkg::cell_pos_t c [4];
        logic hit;
        c = '{p.center, p.b1, p.b2, p.b3};
        hit = 1'b0;
        for (int k = 0; k < 4; k++) begin
            hit |= !on_board(c[k]) || (color_at(c[k]) != '0);
        end
        return hit;
    endfunction

    assign lock_c = '{i_lock_cells.center, i_lock_cells.b1, i_lock_cells.b2, i_lock_cells.b3};

    always_comb begin
        o_now_blocked   = blocked(i_probe_now);
        o_below_blocked = blocked(i_probe_below);
        o_cell_color    = color_at(i_cell_query);
        row_full = 1'b1;
        for (int c = 0; c < WELL_COLS; c++) begin
            row_full &= (cells_q[c][scan_row_q[RW-1:0]] != '0);
        end
    end

    assign o_clear_done   = scan_q && (scan_row_q == LAST_ROW);
    assign o_rows_cleared = found_q + {2'b00, row_full};

    // Row scan, started by each lock
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scan_q     <= 1'b0;
            scan_row_q <= '0;
            found_q    <= '0;
        end else if (i_lock) begin
            scan_q     <= 1'b1;
            scan_row_q <= '0;
            found_q    <= '0;
        end else if (scan_q) begin
            scan_q     <= !o_clear_done;
            scan_row_q <= o_clear_done ? '0 : scan_row_q + 5'd1;
            found_q    <= o_rows_cleared;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_clear_all) begin
            for (int c = 0; c < WELL_COLS; c++) begin
                for (int r = 0; r < WELL_ROWS; r++) begin
                    cells_q[c][r] <= '0;
                end
            end
        end else if (i_lock) begin
            for (int k = 0; k < 4; k++) begin
                if (on_board(lock_c[k])) begin
                    cells_q[lock_c[k].col[CW-1:0]][lock_c[k].row[RW-1:0]] <= i_lock_color;
                end
            end
        end else if (scan_q && row_full) begin
            // Drop everything above the full row by one
            for (int c = 0; c < WELL_COLS; c++) begin
                for (int r = 0; r < WELL_ROWS; r++) begin
                    if (r == 0) begin
                        cells_q[c][r] <= '0;
                    end else if (well_pkg::row_t'(r) <= scan_row_q) begin
                        cells_q[c][r] <= cells_q[c][r-1];
                    end
                end
            end
        end
    end

endmodule

//--- source/play_control.sv
`timescale 1ns/1ps

module play_control #(
    parameter int WELL_COLS      = 10,
    parameter int WELL_ROWS      = 20,
    parameter int GRAVITY_CYCLES = 25000000,
    parameter int STALL_CYCLES   = 2000000
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_start,
    input  well_pkg::key_t         i_key,
    output well_pkg::piece_cells_t o_probe_now,
    output well_pkg::piece_cells_t o_probe_below,
    input  logic                   i_now_blocked,
    input  logic                   i_below_blocked,
    output logic                   o_lock,
    output well_pkg::piece_cells_t o_lock_cells,
    output well_pkg::color_code_t  o_lock_color,
    output logic                   o_clear_all,
    input  logic                   i_clear_done,
    input  logic [2:0]             i_rows_cleared,
    output well_pkg::piece_cells_t o_piece,
    output well_pkg::color_code_t  o_piece_color,
    output logic [7:0]             o_score
);

    localparam int GW = $clog2(GRAVITY_CYCLES + 1);
    localparam int SW = $clog2(STALL_CYCLES + 1);
    localparam logic [GW-1:0] GRAV_LAST  = GW'(GRAVITY_CYCLES - 1);
    localparam logic [SW-1:0] STALL_LAST = SW'(STALL_CYCLES - 1);
    localparam well_pkg::row_t LAST_ROW  = well_pkg::row_t'(WELL_ROWS - 1);
    localparam well_pkg::shape_t LAST_SHAPE = well_pkg::shape_t'(well_pkg::SHAPE_COUNT - 1);
    localparam well_pkg::cell_pos_t SPAWN =
        '{col: well_pkg::col_t'(WELL_COLS / 2 - 1), row: well_pkg::row_t'(0)};

    typedef enum logic [2:0] {
        S_IDLE, S_WAIT, S_CHECK, S_STALL, S_FALL, S_CLEAR
    } state_t;

    state_t                 state_q;
    well_pkg::cell_pos_t    center_q;
    well_pkg::cell_pos_t    land_center;
    well_pkg::row_t         land_q;
    well_pkg::col_t         prev_col_q;
    well_pkg::rot_t         rot_q;
    well_pkg::rot_t         prev_rot_q;
    well_pkg::shape_t       shape_q;
    logic [GW-1:0]          grav_q;
    logic [SW-1:0]          stall_q;
    logic [9:0]             score_q;
    logic                   grav_due;
    well_pkg::piece_cells_t cur_cells;
    well_pkg::piece_cells_t land_cells;

    assign land_center = '{col: center_q.col, row: land_q};

    piece_shape u_cur_shape (
        .i_center (center_q),
        .i_shape  (shape_q),
        .i_rot    (rot_q),
        .o_cells  (cur_cells)
    );

    piece_shape u_land_shape (
        .i_center (land_center),
        .i_shape  (shape_q),
        .i_rot    (rot_q),
        .o_cells  (land_cells)
    );

    always_comb begin
        o_probe_below = land_cells;
        o_probe_below.center.row = land_cells.center.row + 5'd1;
        o_probe_below.b1.row     = land_cells.b1.row + 5'd1;
        o_probe_below.b2.row     = land_cells.b2.row + 5'd1;
        o_probe_below.b3.row     = land_cells.b3.row + 5'd1;
    end

    assign o_probe_now   = cur_cells;
    assign o_piece       = cur_cells;
    assign o_lock_cells  = land_cells;
    assign o_piece_color = well_pkg::color_code_t'(shape_q) + 3'd1;
    assign o_lock_color  = o_piece_color;
    assign o_lock        = (state_q == S_FALL) && (center_q.row == land_q);
    assign o_clear_all   = (state_q == S_IDLE) && i_start;
    assign o_score       = score_q[7:0];
    assign grav_due      = (grav_q == GRAV_LAST);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= S_IDLE;
            center_q   <= SPAWN;
            land_q     <= '0;
            prev_col_q <= '0;
            rot_q      <= '0;
            prev_rot_q <= '0;
            shape_q    <= '0;
            grav_q     <= '0;
            stall_q    <= '0;
            score_q    <= '0;
        end else begin
            if (!grav_due) begin
                grav_q <= grav_q + 1'b1;
            end
            case (state_q)
                S_IDLE: begin
                    if (i_start) begin
                        score_q  <= '0;
                        shape_q  <= '0;
                        rot_q    <= '0;
                        center_q <= SPAWN;
                        land_q   <= '0;
                        grav_q   <= '0;
                        stall_q  <= '0;
                        state_q  <= S_STALL;
                    end
                end
                S_WAIT: begin
                    prev_col_q <= center_q.col;
                    prev_rot_q <= rot_q;
                    case (i_key)
                        well_pkg::KEY_UP: begin
                            rot_q   <= rot_q + 2'd1;
                            state_q <= S_CHECK;
                        end
                        well_pkg::KEY_RIGHT: begin
                            center_q.col <= center_q.col + 4'd1;
                            state_q      <= S_CHECK;
                        end
                        well_pkg::KEY_LEFT: begin
                            center_q.col <= center_q.col - 4'd1;
                            state_q      <= S_CHECK;
                        end
                        // Hard drop straight to the landing row
                        well_pkg::KEY_DOWN: begin
                            center_q.row <= land_q;
                            state_q      <= S_FALL;
                        end
                        default: begin
                            if (grav_due) begin
                                state_q <= S_FALL;
                            end
                        end
                    endcase
                end
                S_CHECK: begin
                    if (i_now_blocked) begin
                        center_q.col <= prev_col_q;
                        rot_q        <= prev_rot_q;
                    end
                    land_q  <= center_q.row;
                    stall_q <= '0;
                    state_q <= S_STALL;
                end
                S_STALL: begin
                    // Landing search, one row per cycle
                    if (!i_below_blocked && land_q != LAST_ROW) begin
                        land_q <= land_q + 5'd1;
                    end
                    stall_q <= stall_q + 1'b1;
                    if (stall_q == STALL_LAST) begin
                        if (land_q == '0) begin
                            state_q <= S_IDLE;
                        end else begin
                            state_q <= grav_due ? S_FALL : S_WAIT;
                        end
                    end
                end
                S_FALL: begin
                    grav_q <= '0;
                    if (center_q.row == land_q) begin
                        state_q <= S_CLEAR;
                    end else begin
                        center_q.row <= center_q.row + 5'd1;
                        state_q      <= S_WAIT;
                    end
                end
                S_CLEAR: begin
                    if (i_clear_done) begin
                        if (i_rows_cleared != '0) begin
                            score_q <= score_q + {6'd0, i_rows_cleared, 1'b0} - 10'd1;
                        end
                        shape_q  <= (shape_q == LAST_SHAPE) ? '0 : shape_q + 3'd1;
                        rot_q    <= '0;
                        center_q <= SPAWN;
                        land_q   <= '0;
                        stall_q  <= '0;
                        state_q  <= S_STALL;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

//--- source/pixel_render.sv
`timescale 1ns/1ps

module pixel_render #(
    parameter int WELL_COLS = 10,
    parameter int WELL_ROWS = 20
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  video_pkg::pixel_pos_t  i_pixel,
    input  well_pkg::piece_cells_t i_piece,
    input  well_pkg::color_code_t  i_piece_color,
    output well_pkg::cell_pos_t    o_cell_query,
    input  well_pkg::color_code_t  i_cell_color,
    output video_pkg::rgb_t        o_rgb
);

    // Far edges of the field, grid line included
    localparam video_pkg::pixel_t FIELD_X1 =
        video_pkg::pixel_t'(video_pkg::FIELD_X0 + WELL_COLS * video_pkg::CELL_PX);
    localparam video_pkg::pixel_t FIELD_Y1 =
        video_pkg::pixel_t'(video_pkg::FIELD_Y0 + WELL_ROWS * video_pkg::CELL_PX);

    video_pkg::pixel_t   dx;
    video_pkg::pixel_t   dy;
    logic                s1_field_q;
    logic                s1_grid_q;
    well_pkg::cell_pos_t s1_cell_q;
    logic                in_piece;
    video_pkg::rgb_t     rgb_next;

    assign dx = i_pixel.x - video_pkg::FIELD_X0;
    assign dy = i_pixel.y - video_pkg::FIELD_Y0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_field_q <= 1'b0;
            s1_grid_q  <= 1'b0;
            s1_cell_q  <= '0;
        end else begin
            s1_field_q <= (i_pixel.x >= video_pkg::FIELD_X0) && (i_pixel.x <= FIELD_X1) &&
                          (i_pixel.y >= video_pkg::FIELD_Y0) && (i_pixel.y <= FIELD_Y1);
            s1_grid_q  <= (dx % video_pkg::CELL_PX == '0) || (dy % video_pkg::CELL_PX == '0);
            s1_cell_q.col <= well_pkg::col_t'(dx / video_pkg::CELL_PX);
            s1_cell_q.row <= well_pkg::row_t'(dy / video_pkg::CELL_PX);
        end
    end

    // Well answers in the same cycle
    assign o_cell_query = s1_cell_q;

    always_comb begin
        in_piece = (s1_cell_q == i_piece.center) || (s1_cell_q == i_piece.b1) ||
                   (s1_cell_q == i_piece.b2) || (s1_cell_q == i_piece.b3);
        if (!s1_field_q) begin
            rgb_next = video_pkg::RGB_BACKGROUND;
        end else if (s1_grid_q) begin
            rgb_next = video_pkg::RGB_GRID;
        end else if (in_piece) begin
            rgb_next = video_pkg::PALETTE[i_piece_color];
        end else begin
            rgb_next = video_pkg::PALETTE[i_cell_color];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rgb <= '0;
        end else begin
            o_rgb <= rgb_next;
        end
    end

endmodule

//--- source/tetris_top.sv
`timescale 1ns/1ps

module tetris_top #(
    parameter int WELL_COLS      = 10,
    parameter int WELL_ROWS      = 20,
    parameter int GRAVITY_CYCLES = 25000000,
    parameter int STALL_CYCLES   = 2000000
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  video_pkg::pixel_pos_t i_pixel,
    input  well_pkg::key_t        i_key,
    output video_pkg::rgb_t       o_rgb,
    output logic [7:0]            o_score
);

    well_pkg::piece_cells_t probe_now;
    well_pkg::piece_cells_t probe_below;
    logic                   now_blocked;
    logic                   below_blocked;
    logic                   lock;
    well_pkg::piece_cells_t lock_cells;
    well_pkg::color_code_t  lock_color;
    logic                   clear_all;
    logic                   clear_done;
    logic [2:0]             rows_cleared;
    well_pkg::piece_cells_t piece;
    well_pkg::color_code_t  piece_color;
    well_pkg::cell_pos_t    cell_query;
    well_pkg::color_code_t  cell_color;

    play_control #(
        .WELL_COLS      (WELL_COLS),
        .WELL_ROWS      (WELL_ROWS),
        .GRAVITY_CYCLES (GRAVITY_CYCLES),
        .STALL_CYCLES   (STALL_CYCLES)
    ) u_play_control (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_key           (i_key),
        .o_probe_now     (probe_now),
        .o_probe_below   (probe_below),
        .i_now_blocked   (now_blocked),
        .i_below_blocked (below_blocked),
        .o_lock          (lock),
        .o_lock_cells    (lock_cells),
        .o_lock_color    (lock_color),
        .o_clear_all     (clear_all),
        .i_clear_done    (clear_done),
        .i_rows_cleared  (rows_cleared),
        .o_piece         (piece),
        .o_piece_color   (piece_color),
        .o_score         (o_score)
    );

    well_board #(
        .WELL_COLS (WELL_COLS),
        .WELL_ROWS (WELL_ROWS)
    ) u_well_board (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_clear_all     (clear_all),
        .i_lock          (lock),
        .i_lock_cells    (lock_cells),
        .i_lock_color    (lock_color),
        .i_probe_now     (probe_now),
        .i_probe_below   (probe_below),
        .o_now_blocked   (now_blocked),
        .o_below_blocked (below_blocked),
        .i_cell_query    (cell_query),
        .o_cell_color    (cell_color),
        .o_clear_done    (clear_done),
        .o_rows_cleared  (rows_cleared)
    );

    pixel_render #(
        .WELL_COLS (WELL_COLS),
        .WELL_ROWS (WELL_ROWS)
    ) u_pixel_render (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_pixel       (i_pixel),
        .i_piece       (piece),
        .i_piece_color (piece_color),
        .o_cell_query  (cell_query),
        .i_cell_color  (cell_color),
        .o_rgb         (o_rgb)
    );

endmodule

//--- test/tetris_tb.sv
`timescale 1ns/1ps

module tetris_tb;

    localparam int WELL_COLS       = 4;
    localparam int WELL_ROWS       = 20;
    localparam int GRAVITY_CYCLES  = 2000;
    localparam int STALL_CYCLES    = 40;
    localparam int SETTLE_CYCLES   = 2 * STALL_CYCLES + WELL_ROWS + 10;
    localparam int WATCHDOG_CYCLES = 30 * SETTLE_CYCLES + 2 * GRAVITY_CYCLES;
    localparam int KEY_HOLD        = 10;
    localparam int MAX_DROPS       = 20;
    localparam int X0              = 220;
    localparam int Y0              = 40;
    localparam int PX              = 20;
    localparam logic [23:0] BACKGROUND = 24'h141414;
    localparam logic [23:0] GRID       = 24'hFFFFFF;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  start;
    video_pkg::pixel_pos_t pixel;
    well_pkg::key_t        key;
    video_pkg::rgb_t       rgb;
    logic [7:0]            score;

    int unsigned           cycle_count = 0;
    int unsigned           start_cycle = 0;
    logic [2:0]            exp_code [WELL_COLS][WELL_ROWS];
    video_pkg::pixel_pos_t pix_q [$];
    logic [23:0]           got_q [$];
    logic [23:0]           shot [WELL_COLS * WELL_ROWS];

    tetris_top #(
        .WELL_COLS      (WELL_COLS),
        .WELL_ROWS      (WELL_ROWS),
        .GRAVITY_CYCLES (GRAVITY_CYCLES),
        .STALL_CYCLES   (STALL_CYCLES)
    ) UUT (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_start (start),
        .i_pixel (pixel),
        .i_key   (key),
        .o_rgb   (rgb),
        .o_score (score)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    task automatic report_mismatch(input string test, input logic [23:0] expected,
                                   input logic [23:0] actual);
        $display("error %s: expected %h, actual %h", test, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [23:0] rgb_of(logic [2:0] code);
        case (code)
            3'd1: return 24'hFF1414;
            3'd2: return 24'h14FF14;
            3'd3: return 24'h1414FF;
            3'd4: return 24'h14FFFF;
            3'd5: return 24'hFF14FF;
            3'd6: return 24'hFFFF14;
            3'd7: return 24'hFF6400;
            default: return BACKGROUND;
        endcase
    endfunction

    function automatic video_pkg::pixel_pos_t pos(int x, int y);
        video_pkg::pixel_pos_t p;
        p.x = video_pkg::pixel_t'(x);
        p.y = video_pkg::pixel_t'(y);
        return p;
    endfunction

    // Screen colour a pixel must show for the expected cell colours
    function automatic logic [23:0] expected_rgb(video_pkg::pixel_pos_t p);
        int dx;
        int dy;
        dx = int'(p.x) - X0;
        dy = int'(p.y) - Y0;
        if (dx < 0 || dx > WELL_COLS * PX || dy < 0 || dy > WELL_ROWS * PX) begin
            return BACKGROUND;
        end
        if (dx % PX == 0 || dy % PX == 0) begin
            return GRID;
        end
        return rgb_of(exp_code[dx / PX][dy / PX]);
    endfunction

    function automatic void clear_expected();
        for (int c = 0; c < WELL_COLS; c++) begin
            for (int r = 0; r < WELL_ROWS; r++) begin
                exp_code[c][r] = 3'd0;
            end
        end
    endfunction

    function automatic void mark(int c, int r, int code);
        if (c >= 0 && c < WELL_COLS && r >= 0 && r < WELL_ROWS) begin
            exp_code[c][r] = 3'(code);
        end
    endfunction

    // Z piece in red around its centre cell
    function automatic void mark_z_piece(int c, int r, int rot);
        if (rot % 2 == 0) begin
            mark(c - 1, r, 1);
            mark(c, r, 1);
            mark(c, r + 1, 1);
            mark(c + 1, r + 1, 1);
        end else begin
            mark(c, r - 1, 1);
            mark(c, r, 1);
            mark(c - 1, r, 1);
            mark(c - 1, r + 1, 1);
        end
    endfunction

    // One pixel per cycle with each result read two cycles later
    task automatic stream_pixels();
        int n;
        n = pix_q.size();
        got_q.delete();
        for (int j = 0; j < n + 2; j++) begin
            @(posedge clk);
            #1;
            if (j >= 2) begin
                got_q.push_back(rgb);
            end
            if (j < n) begin
                pixel = pix_q[j];
            end
        end
    endtask

    task automatic capture_screen();
        pix_q.delete();
        for (int r = 0; r < WELL_ROWS; r++) begin
            for (int c = 0; c < WELL_COLS; c++) begin
                pix_q.push_back(pos(X0 + c * PX + PX / 2, Y0 + r * PX + PX / 2));
            end
        end
        stream_pixels();
    endtask

    task automatic check_screen(input string test, input int first_row);
        int k;
        capture_screen();
        for (int r = first_row; r < WELL_ROWS; r++) begin
            for (int c = 0; c < WELL_COLS; c++) begin
                k = r * WELL_COLS + c;
                assert (got_q[k] == rgb_of(exp_code[c][r]))
                    else report_mismatch($sformatf("%s cell (%0d,%0d)", test, c, r),
                                         rgb_of(exp_code[c][r]), got_q[k]);
            end
        end
    endtask

    task automatic check_score(input string test, input int expected);
        assert (score == 8'(expected))
            else report_mismatch(test, 24'(expected), {16'd0, score});
    endtask

    task automatic take_snapshot();
        for (int k = 0; k < WELL_COLS * WELL_ROWS; k++) begin
            shot[k] = got_q[k];
        end
    endtask

    function automatic bit screen_same();
        for (int k = 0; k < WELL_COLS * WELL_ROWS; k++) begin
            if (got_q[k] != shot[k]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic press_key(input well_pkg::key_t k);
        @(posedge clk);
        #1;
        key = k;
        repeat (KEY_HOLD) @(posedge clk);
        #1;
        key = '0;
        repeat (SETTLE_CYCLES) @(posedge clk);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        start = 1'b0;
        key   = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic start_game();
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        start_cycle = cycle_count;
        #1;
        start = 1'b0;
        repeat (SETTLE_CYCLES) @(posedge clk);
    endtask

    initial begin
        video_pkg::pixel_pos_t p;
        bit                    over;
        rst_n = 1'b0;
        start = 1'b0;
        key   = '0;
        pixel = '0;
        void'($urandom(91));

        apply_reset();
        start_game();

        // Latency and layout with the spawned Z drawn
        clear_expected();
        mark_z_piece(1, 0, 0);
        pix_q.delete();
        pix_q.push_back(pos(X0, Y0));
        pix_q.push_back(pos(X0 - 1, Y0 + 5));
        pix_q.push_back(pos(X0 + WELL_COLS * PX, Y0 + WELL_ROWS * PX));
        pix_q.push_back(pos(X0 + WELL_COLS * PX + 1, Y0 + 30));
        for (int n = 0; n < 120; n++) begin
            p.x = video_pkg::pixel_t'(190 + $urandom % 140);
            p.y = video_pkg::pixel_t'(20 + $urandom % 440);
            pix_q.push_back(p);
        end
        stream_pixels();
        for (int n = 0; n < pix_q.size(); n++) begin
            assert (got_q[n] == expected_rgb(pix_q[n]))
                else report_mismatch("layout", expected_rgb(pix_q[n]), got_q[n]);
        end

        check_screen("spawn", 0);
        check_score("spawn score", 0);

        press_key(well_pkg::KEY_RIGHT);
        clear_expected();
        mark_z_piece(2, 0, 0);
        check_screen("move right", 0);

        press_key(well_pkg::KEY_LEFT);
        clear_expected();
        mark_z_piece(1, 0, 0);
        check_screen("move left", 0);

        // Gravity counter runs from the start of the game
        while (cycle_count < start_cycle + GRAVITY_CYCLES + SETTLE_CYCLES) begin
            @(posedge clk);
        end
        clear_expected();
        mark_z_piece(1, 1, 0);
        check_screen("gravity", 0);

        press_key(well_pkg::KEY_UP);
        clear_expected();
        mark_z_piece(1, 1, 1);
        check_screen("rotate", 0);

        press_key(well_pkg::KEY_UP);
        clear_expected();
        mark_z_piece(1, 1, 0);
        check_screen("rotate back", 0);

        // Hard drops on a fresh well with the spawn rows left out
        apply_reset();
        start_game();
        clear_expected();

        press_key(well_pkg::KEY_DOWN);
        mark(0, 18, 1);
        mark(1, 18, 1);
        mark(1, 19, 1);
        mark(2, 19, 1);
        check_screen("drop Z", 2);
        check_score("drop Z score", 0);

        press_key(well_pkg::KEY_DOWN);
        mark(1, 16, 2);
        mark(2, 16, 2);
        mark(0, 17, 2);
        mark(1, 17, 2);
        check_screen("drop S", 2);
        check_score("drop S score", 0);

        press_key(well_pkg::KEY_DOWN);
        mark(0, 14, 3);
        mark(1, 14, 3);
        mark(2, 14, 3);
        mark(1, 15, 3);
        check_screen("drop T", 2);
        check_score("drop T score", 0);

        // I fills row 13 and clears it
        press_key(well_pkg::KEY_DOWN);
        check_screen("drop I", 2);
        check_score("drop I score", 1);

        // Drop until a down key no longer changes the screen
        capture_screen();
        take_snapshot();
        over = 1'b0;
        for (int n = 0; n < MAX_DROPS && !over; n++) begin
            press_key(well_pkg::KEY_DOWN);
            capture_screen();
            if (screen_same()) begin
                over = 1'b1;
            end else begin
                take_snapshot();
            end
        end
        assert (over)
            else report_failure("Game over was not reached within the drop limit");
        press_key(well_pkg::KEY_RIGHT);
        capture_screen();
        for (int k = 0; k < WELL_COLS * WELL_ROWS; k++) begin
            assert (got_q[k] == shot[k])
                else report_mismatch($sformatf("game over cell %0d", k), shot[k], got_q[k]);
        end
        // Second I piece lands on row 1 and clears it
        check_score("game over score", 2);

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- tb.f
source/well_pkg.sv
source/video_pkg.sv
source/piece_shape.sv
source/well_board.sv
source/play_control.sv
source/pixel_render.sv
source/tetris_top.sv
test/tetris_tb.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tetris_tb -o tetris_sim \
    && ./obj_dir/tetris_sim | tee /dev/stderr | grep -q "NO ERRORS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
